// ==== verilog/loader_pkg.sv ====
// Shared widths, file indexes and packed buses of the download path
// File indexes compare against the low six bits of the host index
`default_nettype none

package loader_pkg;

	// ============================================================
	// Widths
	// ============================================================
	localparam int IOCTL_ADDR_W = 27;
	localparam int IOCTL_DATA_W = 16;
	localparam int MEM_WORD_W   = 32;
	localparam int PIF_ADDR_W   = 10;

	// File indexes from the host menu
	localparam logic [5:0] IDX_PIF       = 6'd0;
	localparam logic [5:0] IDX_CART_MAIN = 6'd1;
	localparam logic [5:0] IDX_CART_GB   = 6'd2;

	// Handheld cart lands 8 MB into the external memory
	localparam logic [IOCTL_ADDR_W-1:0] CART_GB_BASE = 27'd8388608;

	// Write buffer, two entries of margin for the registered wait
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AFULL = FIFO_DEPTH - 2;

	// ============================================================
	// Buses
	// ============================================================
	typedef struct packed {
		logic                    download;
		logic                    wr;
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [IOCTL_DATA_W-1:0] data;
		logic [7:0]              index;
	} ioctl_bus_t;

	typedef struct packed {
		logic [IOCTL_ADDR_W-1:0] addr;
		logic [MEM_WORD_W-1:0]   data;
	} mem_word_t;

	typedef struct packed {
		logic [PIF_ADDR_W-1:0] addr;
		logic [MEM_WORD_W-1:0] data;
	} pif_write_t;

endpackage

`default_nettype wire

// ==== verilog/ioctl_word_packer.sv ====
// Expects the even half-word (addr bit 1 clear) before its odd partner
// Download flags lag ioctl download by one cycle, so the host must raise it early
`timescale 1ns/100ps
`default_nettype none

module ioctl_word_packer (
	input  wire                                     clk_1x,
	input  wire                                     RESET,
	input  wire loader_pkg::ioctl_bus_t             ioctl,
	output loader_pkg::pif_write_t                  pif,
	output logic                                    pif_wren,
	output logic                                    push,
	output loader_pkg::mem_word_t                   push_word,
	output logic                                    romcopy_start,
	output logic [loader_pkg::IOCTL_ADDR_W-1:0]     romcopy_size,
	output logic                                    cart_loaded
);

	// Registered per-index download flags
	logic pif_download;
	logic main_download;
	logic gb_download;
	logic download_d;

	// Even half-word waiting for its odd partner
	logic [loader_pkg::IOCTL_ADDR_W-1:0] even_addr;
	logic [loader_pkg::IOCTL_DATA_W-1:0] even_data;
	logic                                even_idx6;

	logic [5:0] file_idx;
	logic       wr_even;
	logic       wr_odd;
	logic       main_done;

	assign file_idx  = ioctl.index[5:0];
	assign wr_even   = ioctl.wr & ~ioctl.addr[1];
	assign wr_odd    = ioctl.wr & ioctl.addr[1];
	// Falling edge of the main cart download
	assign main_done = ~ioctl.download & download_d & (file_idx == loader_pkg::IDX_CART_MAIN);

	// ============================================================
	// Control
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_download  <= 1'b0;
			main_download <= 1'b0;
			gb_download   <= 1'b0;
			download_d    <= 1'b0;
			pif_wren      <= 1'b0;
			push          <= 1'b0;
			romcopy_start <= 1'b0;
			cart_loaded   <= 1'b0;
		end else begin
			pif_download  <= ioctl.download & (file_idx == loader_pkg::IDX_PIF);
			main_download <= ioctl.download & (file_idx == loader_pkg::IDX_CART_MAIN);
			gb_download   <= ioctl.download & (file_idx == loader_pkg::IDX_CART_GB);
			download_d    <= ioctl.download;

			pif_wren      <= pif_download & wr_odd;
			push          <= gb_download & wr_odd;
			romcopy_start <= main_done;

			if (main_download) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	// ============================================================
	// Payload
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (wr_even) begin
			even_addr <= ioctl.addr;
			even_data <= ioctl.data;
			even_idx6 <= ioctl.index[6];
		end

		// Boot ROM word is stored byte-swapped within each half
		if (pif_download && wr_odd) begin
			pif.addr         <= {even_idx6, even_addr[10:2]};
			pif.data[31:24]  <= even_data[7:0];
			pif.data[23:16]  <= even_data[15:8];
			pif.data[15:8]   <= ioctl.data[7:0];
			pif.data[7:0]    <= ioctl.data[15:8];
		end

		// Cart word packs the even half in the low half
		if (gb_download && wr_odd) begin
			push_word.addr <= even_addr + loader_pkg::CART_GB_BASE;
			push_word.data <= {ioctl.data, even_data};
		end

		if (main_done) begin
			romcopy_size <= ioctl.addr;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/write_fifo.sv ====
// DEPTH must be a power of two; almost_full trips at the shared threshold
// A push into a full buffer or a pop from an empty one is ignored
`timescale 1ns/100ps
`default_nettype none

module write_fifo #(
	parameter int DEPTH = loader_pkg::FIFO_DEPTH
) (
	input  wire                         clk_1x,
	input  wire                         RESET,
	input  wire                         push,
	input  wire loader_pkg::mem_word_t  push_word,
	input  wire                         pop,
	output loader_pkg::mem_word_t       head,
	output logic                        empty,
	output logic                        almost_full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	loader_pkg::mem_word_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_push;
	logic             do_pop;

	assign full        = (count == CNT_W'(DEPTH));
	assign empty       = (count == '0);
	assign almost_full = (count >= CNT_W'(loader_pkg::FIFO_AFULL));
	assign do_push     = push & ~full;
	assign do_pop      = pop & ~empty;

	// Head is read straight from storage
	assign head = mem[rd_ptr];

	always_ff @(posedge clk_1x) begin
		if (do_push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	// ============================================================
	// Pointers and occupancy
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap naturally at a power-of-two depth
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_write_port.sv ====
// Write-only four-phase req/ack master, one transfer at a time
// mem_word holds from the rise of mem_req until mem_ack has fallen
`timescale 1ns/100ps
`default_nettype none

module mem_write_port (
	input  wire                         clk_1x,
	input  wire                         RESET,
	input  wire                         empty,
	input  wire loader_pkg::mem_word_t  head,
	input  wire                         mem_ack,
	output logic                        pop,
	output logic                        mem_req,
	output loader_pkg::mem_word_t       mem_word
);

	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_REQ     = 2'd1,
		ST_RELEASE = 2'd2
	} port_state_t;

	port_state_t state;

	// Take the head as soon as the port is free
	assign pop     = (state == ST_IDLE) & ~empty;
	assign mem_req = (state == ST_REQ);

	// ============================================================
	// Handshake FSM
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (!empty) begin
						state <= ST_REQ;
					end
				end
				ST_REQ: begin
					// Ack marks the write as done
					if (mem_ack) begin
						state <= ST_RELEASE;
					end
				end
				ST_RELEASE: begin
					// Wait for ack to drop before the next request
					if (!mem_ack) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_1x) begin
		if (pop) begin
			mem_word <= head;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/rom_loader_top.sv ====
// Download path from the ioctl port to boot ROM, cart memory and copy trigger
// Host must honour ioctl_wait as seen at the previous clock edge
`timescale 1ns/100ps
`default_nettype none

module rom_loader_top (
	input  wire                                     clk_1x,
	input  wire                                     RESET,
	input  wire loader_pkg::ioctl_bus_t             ioctl,
	input  wire                                     mem_ack,
	output logic                                    ioctl_wait,
	output loader_pkg::pif_write_t                  pif,
	output logic                                    pif_wren,
	output logic                                    mem_req,
	output loader_pkg::mem_word_t                   mem_word,
	output logic                                    romcopy_start,
	output logic [loader_pkg::IOCTL_ADDR_W-1:0]     romcopy_size,
	output logic                                    cart_loaded
);

	logic                  push;
	loader_pkg::mem_word_t push_word;
	logic                  pop;
	loader_pkg::mem_word_t head;
	logic                  empty;
	logic                  almost_full;

	// ============================================================
	// Host throttle
	// ============================================================
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			ioctl_wait <= 1'b0;
		end else begin
			ioctl_wait <= almost_full;
		end
	end

	ioctl_word_packer i_ioctl_word_packer (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.ioctl         (ioctl),
		.pif           (pif),
		.pif_wren      (pif_wren),
		.push          (push),
		.push_word     (push_word),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.cart_loaded   (cart_loaded)
	);

	write_fifo #(
		.DEPTH (loader_pkg::FIFO_DEPTH)
	) i_write_fifo (
		.clk_1x      (clk_1x),
		.RESET       (RESET),
		.push        (push),
		.push_word   (push_word),
		.pop         (pop),
		.head        (head),
		.empty       (empty),
		.almost_full (almost_full)
	);

	mem_write_port i_mem_write_port (
		.clk_1x   (clk_1x),
		.RESET    (RESET),
		.empty    (empty),
		.head     (head),
		.mem_ack  (mem_ack),
		.pop      (pop),
		.mem_req  (mem_req),
		.mem_word (mem_word)
	);

endmodule

`default_nettype wire

// ==== tests/loader_checker.sv ====
// Scoreboard for the download path; expectations are built from the ioctl writes it sees
// Row details arrive from the testbench; test_done closes one test
`timescale 1ns/100ps
`default_nettype none

module loader_checker (
	input  wire                                 clk_1x,
	input  wire                                 RESET,
	input  wire loader_pkg::ioctl_bus_t         ioctl,
	input  wire                                 ioctl_wait,
	input  wire loader_pkg::pif_write_t         pif,
	input  wire                                 pif_wren,
	input  wire                                 mem_req,
	input  wire                                 mem_ack,
	input  wire loader_pkg::mem_word_t          mem_word,
	input  wire                                 romcopy_start,
	input  wire [loader_pkg::IOCTL_ADDR_W-1:0]  romcopy_size,
	input  wire                                 cart_loaded,
	input  wire [31:0]                          cur_test,
	input  wire [7:0]                           cur_index,
	input  wire [loader_pkg::IOCTL_ADDR_W-1:0]  cur_start,
	input  wire [31:0]                          cur_words,
	input  wire                                 cur_need_wait,
	input  wire                                 test_done,
	output logic [31:0]                         pending,
	output logic [31:0]                         err_count,
	output logic [31:0]                         tests_run,
	output logic [31:0]                         tests_failed
);

	typedef logic [loader_pkg::IOCTL_ADDR_W-1:0] addr_t;

	loader_pkg::pif_write_t pif_q[$];
	loader_pkg::mem_word_t  mem_q[$];

	addr_t       even_addr;
	logic [15:0] even_data;
	logic        even_idx6;
	logic        ack_prev;
	logic        wait_seen;
	logic        reset_checked;
	int          pif_cnt;
	int          mem_cnt;
	int          copy_cnt;
	addr_t       copy_size;
	int          errs;
	int          errs_at_start;
	int          done_tests;
	int          bad_tests;

	task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("[FAIL] test %0d: %s got %h expected %h", cur_test, name, got, exp);
		errs++;
	endtask

	task automatic plain_error(input string what);
		$display("test %0d: %s", cur_test, what);
		errs++;
	endtask

	initial begin
		errs          = 0;
		errs_at_start = 0;
		done_tests    = 0;
		bad_tests     = 0;
		pif_cnt       = 0;
		mem_cnt       = 0;
		copy_cnt      = 0;
		wait_seen     = 1'b0;
		ack_prev      = 1'b0;
		reset_checked = 1'b0;
		copy_size     = '0;
	end

	// ============================================================
	// Sampling on every rising edge
	// ============================================================
	always @(posedge clk_1x) begin
		loader_pkg::pif_write_t exp_pif;
		loader_pkg::mem_word_t  exp_mem;
		int                     exp_pif_cnt;
		int                     exp_mem_cnt;
		int                     exp_copy_cnt;
		addr_t                  exp_size;

		if (RESET) begin
			if (!reset_checked) begin
				reset_checked = 1'b1;
				if (pif_wren !== 1'b0) value_error("pif_wren", 64'(pif_wren), 64'h0);
				if (mem_req !== 1'b0) value_error("mem_req", 64'(mem_req), 64'h0);
				if (romcopy_start !== 1'b0) begin
					value_error("romcopy_start", 64'(romcopy_start), 64'h0);
				end
				if (ioctl_wait !== 1'b0) value_error("ioctl_wait", 64'(ioctl_wait), 64'h0);
				if (cart_loaded !== 1'b0) value_error("cart_loaded", 64'(cart_loaded), 64'h0);
				$display("test 0 (reset state): %s", (errs == 0) ? "pass" : "fail");
				done_tests++;
				if (errs != 0) bad_tests++;
				errs_at_start = errs;
			end

			// Expected writes from the host side
			if (ioctl.wr && !ioctl.addr[1]) begin
				even_addr = ioctl.addr;
				even_data = ioctl.data;
				even_idx6 = ioctl.index[6];
			end
			if (ioctl.download && ioctl.wr && ioctl.addr[1]) begin
				if (ioctl.index[5:0] == loader_pkg::IDX_PIF) begin
					exp_pif.addr = {even_idx6, even_addr[10:2]};
					exp_pif.data = {even_data[7:0], even_data[15:8],
						ioctl.data[7:0], ioctl.data[15:8]};
					pif_q.push_back(exp_pif);
				end else if (ioctl.index[5:0] == loader_pkg::IDX_CART_GB) begin
					exp_mem.addr = even_addr + loader_pkg::CART_GB_BASE;
					exp_mem.data = {ioctl.data, even_data};
					mem_q.push_back(exp_mem);
				end
			end

			if (pif_wren) begin
				pif_cnt++;
				if (pif_q.size() == 0) begin
					plain_error("boot ROM write arrived with none expected");
				end else begin
					exp_pif = pif_q.pop_front();
					if (pif.addr != exp_pif.addr) begin
						value_error("pif.addr", 64'(pif.addr), 64'(exp_pif.addr));
					end
					if (pif.data != exp_pif.data) begin
						value_error("pif.data", 64'(pif.data), 64'(exp_pif.data));
					end
				end
			end

			// A memory write completes on the rising edge of ack
			if (mem_req && mem_ack && !ack_prev) begin
				mem_cnt++;
				if (mem_q.size() == 0) begin
					plain_error("memory write arrived with none expected");
				end else begin
					exp_mem = mem_q.pop_front();
					if (mem_word.addr != exp_mem.addr) begin
						value_error("mem_word.addr", 64'(mem_word.addr), 64'(exp_mem.addr));
					end
					if (mem_word.data != exp_mem.data) begin
						value_error("mem_word.data", 64'(mem_word.data), 64'(exp_mem.data));
					end
				end
			end
			ack_prev = mem_ack;

			if (romcopy_start) begin
				copy_cnt++;
				copy_size = romcopy_size;
			end
			if (ioctl_wait) wait_seen = 1'b1;

			// ============================================================
			// End of one test
			// ============================================================
			if (test_done) begin
				exp_pif_cnt  = (cur_index[5:0] == loader_pkg::IDX_PIF) ? int'(cur_words) : 0;
				exp_mem_cnt  = (cur_index[5:0] == loader_pkg::IDX_CART_GB) ? int'(cur_words) : 0;
				exp_copy_cnt = (cur_index[5:0] == loader_pkg::IDX_CART_MAIN) ? 1 : 0;
				exp_size     = cur_start + addr_t'(4 * cur_words - 2);
				if (pif_cnt != exp_pif_cnt) begin
					value_error("pif_wren count", 64'(pif_cnt), 64'(exp_pif_cnt));
				end
				if (mem_cnt != exp_mem_cnt) begin
					value_error("mem write count", 64'(mem_cnt), 64'(exp_mem_cnt));
				end
				if (copy_cnt != exp_copy_cnt) begin
					value_error("romcopy_start count", 64'(copy_cnt), 64'(exp_copy_cnt));
				end
				if (exp_copy_cnt == 1) begin
					if (copy_size != exp_size) begin
						value_error("romcopy_size", 64'(copy_size), 64'(exp_size));
					end
					if (cart_loaded !== 1'b1) begin
						value_error("cart_loaded", 64'(cart_loaded), 64'h1);
					end
				end
				if (cur_need_wait && !wait_seen) plain_error("ioctl_wait never went high");
				if (pif_q.size() != 0 || mem_q.size() != 0) begin
					plain_error("expected writes were never seen");
				end
				$display("test %0d (index %0d, %0d words): %s", cur_test, cur_index, cur_words,
					(errs == errs_at_start) ? "pass" : "fail");
				done_tests++;
				if (errs != errs_at_start) bad_tests++;
				errs_at_start = errs;
				pif_cnt   = 0;
				mem_cnt   = 0;
				copy_cnt  = 0;
				wait_seen = 1'b0;
			end
		end
		pending      <= 32'(pif_q.size() + mem_q.size());
		err_count    <= 32'(errs);
		tests_run    <= 32'(done_tests);
		tests_failed <= 32'(bad_tests);
	end

endmodule

`default_nettype wire

// ==== tests/tb_rom_loader.sv ====
// Drives the download port from a row table and acks memory writes after a random delay
// A watchdog ends a run that outlasts the table's worst case
`timescale 1ns/100ps
`default_nettype none

module tb_rom_loader;

	typedef logic [loader_pkg::IOCTL_ADDR_W-1:0] addr_t;

	typedef struct {
		logic [7:0]  index;
		addr_t       start;
		int          n_words;
		logic [15:0] seed;
		int          max_delay;
		logic        need_wait;
	} row_t;

	logic                    clk_1x;
	logic                    RESET;
	loader_pkg::ioctl_bus_t  ioctl;
	logic                    mem_ack;
	logic                    ioctl_wait;
	loader_pkg::pif_write_t  pif;
	logic                    pif_wren;
	logic                    mem_req;
	loader_pkg::mem_word_t   mem_word;
	logic                    romcopy_start;
	addr_t                   romcopy_size;
	logic                    cart_loaded;

	logic [31:0] cur_test;
	logic [7:0]  cur_index;
	addr_t       cur_start;
	logic [31:0] cur_words;
	logic        cur_need_wait;
	logic        test_done;
	int          cur_max_delay;
	logic [31:0] pending;
	logic [31:0] err_count;
	logic [31:0] tests_run;
	logic [31:0] tests_failed;

	row_t rows[$];

	rom_loader_top i_rom_loader_top (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.ioctl         (ioctl),
		.mem_ack       (mem_ack),
		.ioctl_wait    (ioctl_wait),
		.pif           (pif),
		.pif_wren      (pif_wren),
		.mem_req       (mem_req),
		.mem_word      (mem_word),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size),
		.cart_loaded   (cart_loaded)
	);

	loader_checker i_loader_checker (
		.clk_1x (clk_1x), .RESET (RESET), .ioctl (ioctl), .ioctl_wait (ioctl_wait),
		.pif (pif), .pif_wren (pif_wren), .mem_req (mem_req), .mem_ack (mem_ack),
		.mem_word (mem_word), .romcopy_start (romcopy_start), .romcopy_size (romcopy_size),
		.cart_loaded (cart_loaded), .cur_test (cur_test), .cur_index (cur_index),
		.cur_start (cur_start), .cur_words (cur_words), .cur_need_wait (cur_need_wait),
		.test_done (test_done), .pending (pending), .err_count (err_count),
		.tests_run (tests_run), .tests_failed (tests_failed)
	);

	initial begin
		clk_1x = 1'b0;
		forever #20 clk_1x = ~clk_1x;
	end

	function automatic logic [15:0] half_data(input logic [15:0] seed, input int h);
		return seed ^ (16'(h) * 16'h1357) ^ 16'(h << 12);
	endfunction

	task automatic add_row(input logic [7:0] index, input addr_t start, input int n_words,
			input logic [15:0] seed, input int max_delay, input logic need_wait);
		row_t r;
		r.index     = index;
		r.start     = start;
		r.n_words   = n_words;
		r.seed      = seed;
		r.max_delay = max_delay;
		r.need_wait = need_wait;
		rows.push_back(r);
	endtask

	// ============================================================
	// Apply one row of the table and wait for the path to drain
	// ============================================================
	task automatic apply_row(input int num, input row_t r);
		cur_test      <= 32'(num);
		cur_index     <= r.index;
		cur_start     <= r.start;
		cur_words     <= 32'(r.n_words);
		cur_need_wait <= r.need_wait;
		cur_max_delay <= r.max_delay;
		ioctl.index    <= r.index;
		ioctl.addr     <= r.start;
		ioctl.download <= 1'b1;
		repeat (2) @(posedge clk_1x);
		for (int h = 0; h < 2 * r.n_words; h++) begin
			@(posedge clk_1x);
			while (ioctl_wait) @(posedge clk_1x);
			ioctl.wr   <= 1'b1;
			ioctl.addr <= r.start + addr_t'(2 * h);
			ioctl.data <= half_data(r.seed, h);
			@(posedge clk_1x);
			ioctl.wr   <= 1'b0;
		end
		@(posedge clk_1x);
		ioctl.download <= 1'b0;
		@(posedge clk_1x);
		while (pending != 0 || mem_req || mem_ack) @(posedge clk_1x);
		repeat (4) @(posedge clk_1x);
		test_done <= 1'b1;
		@(posedge clk_1x);
		test_done <= 1'b0;
		@(posedge clk_1x);
	endtask

	// Memory side acks one four-phase transfer at a time
	initial begin : responder
		int unsigned delay;
		void'($urandom(32'h90e1));
		mem_ack <= 1'b0;
		forever begin
			@(posedge clk_1x);
			if (mem_req && !mem_ack) begin
				delay = $urandom % (cur_max_delay + 1);
				repeat (delay) @(posedge clk_1x);
				mem_ack <= 1'b1;
				@(posedge clk_1x);
				while (mem_req) @(posedge clk_1x);
				mem_ack <= 1'b0;
			end
		end
	end

	initial begin : watchdog
		int limit;
		#1;
		limit = 200;
		foreach (rows[i]) begin
			limit += 20 + rows[i].n_words * (12 + rows[i].max_delay + 8);
		end
		repeat (limit) @(posedge clk_1x);
		$display("Timeout: run did not finish within %0d clock cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		RESET         <= 1'b0;
		ioctl         <= '0;
		cur_test      <= '0;
		cur_index     <= '0;
		cur_start     <= '0;
		cur_words     <= '0;
		cur_need_wait <= 1'b0;
		cur_max_delay <= 1;
		test_done     <= 1'b0;

		// index, start, words, seed, max ack delay, wait expected
		add_row(8'd0,  27'h000, 4,  16'h1234, 1,  1'b0);
		add_row(8'd64, 27'h100, 4,  16'h5a00, 1,  1'b0);
		add_row(8'd2,  27'h000, 6,  16'h2200, 1,  1'b0);
		add_row(8'd2,  27'h400, 24, 16'h7700, 12, 1'b1);
		add_row(8'd1,  27'h000, 5,  16'h3300, 1,  1'b0);
		add_row(8'd3,  27'h000, 4,  16'h4400, 1,  1'b0);

		repeat (10) @(posedge clk_1x);
		RESET <= 1'b1;
		repeat (3) @(posedge clk_1x);

		foreach (rows[i]) begin
			apply_row(i + 1, rows[i]);
		end

		repeat (2) @(posedge clk_1x);
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
		if (err_count == 0 && tests_run == 32'(rows.size() + 1)) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
verilog/loader_pkg.sv
verilog/ioctl_word_packer.sv
verilog/write_fifo.sv
verilog/mem_write_port.sv
verilog/rom_loader_top.sv
tests/loader_checker.sv
tests/tb_rom_loader.sv

// ==== Makefile ====
# Verilator build and run of the ROM loader testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := tb_rom_loader
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(wildcard verilog/*.sv tests/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)

check: run
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
